//--- compile.f
+incdir+.
mulArray_pkg.sv
seqMultiplier.sv
jobDispatcher.sv
resultCollector.sv
apbMulRegs.sv
mulArray.sv
mulArray_assertions.sv
mulArray_tb.sv

//--- mulArray_tb.sv
`default_nettype none

`include "mulArray_params.svh"

module mulArray_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mulArray_pkg::*;

    localparam int READY_TIMEOUT = 100;
    localparam int POLL_LIMIT    = 60;
    localparam int BURST_JOBS    = `MUL_UNITS + 3;

    logic                  clk;
    logic                  reset;
    apbReq_t               apbReq;
    apbRsp_t               apbRsp;
    logic [31:0]           lcgState;
    logic [`TAG_WIDTH-1:0] expTag;
    mulResult_t            expected [$];
    int                    mismatches;
    int                    otherFailures;
    int                    assertFails;

    mulArray UUT (
        .clk    (clk),
        .reset  (reset),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic expectEqual(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch %s: expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB transfers, entered and left just after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apbAccess(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err, output int waited);
        int   cycles;
        logic ready;
        rdata          = '0;
        err            = 1'b0;
        cycles         = 0;
        ready          = 1'b0;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #2;
        apbReq.penable = 1'b1;
        // pready is sampled mid-cycle, where it is settled.
        while (!ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            ready = apbRsp.pready;
            rdata = apbRsp.prdata;
            err   = apbRsp.pslverr;
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!ready) begin
            otherFailures++;
            $display("Timeout: pready stayed low at address 0x%03h", addr);
        end
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        waited         = cycles - 1;
    endtask

    task automatic writeOperands(input logic signed [15:0] mcand,
                                 input logic signed [15:0] mplier, output int waited);
        mulResult_t          exp;
        logic signed [31:0]  prod;
        logic [31:0]         rdata;
        logic                err;
        prod        = mcand * mplier;
        exp.product = prod;
        exp.tag     = expTag;
        apbAccess(1'b1, `ADDR_OPERANDS, {mplier, mcand}, rdata, err, waited);
        expectEqual("operand write error", 32'd0, {31'd0, err});
        expected.push_back(exp);
        expTag++;
    endtask

    task automatic waitForResults(input int n);
        logic [31:0] status;
        logic        err;
        int          waited;
        int          polls;
        polls  = 0;
        status = '0;
        do begin
            apbAccess(1'b0, `ADDR_STATUS, '0, status, err, waited);
            expectEqual("status count bound", 32'd1, {31'd0, status[3:0] <= `RES_DEPTH});
            polls++;
        end while (status[3:0] < n && polls < POLL_LIMIT);
        if (status[3:0] < n) begin
            otherFailures++;
            $display("Timeout: only %0d of %0d results arrived", status[3:0], n);
        end
    endtask

    task automatic readAndCheckResult(input string name);
        mulResult_t  exp;
        logic [31:0] rdata;
        logic        err;
        int          waited;
        if (expected.size() == 0) begin
            otherFailures++;
            $display("No expected result left to compare for %s", name);
        end else begin
            exp = expected.pop_front();
            apbAccess(1'b0, `ADDR_TAG, '0, rdata, err, waited);
            expectEqual({name, " tag"}, 32'(exp.tag), rdata);
            apbAccess(1'b0, `ADDR_RESULT, '0, rdata, err, waited);
            expectEqual({name, " product"}, exp.product, rdata);
            expectEqual({name, " read error"}, 32'd0, {31'd0, err});
        end
    endtask

    task automatic checkProduct(input logic [15:0] mcand, input logic [15:0] mplier,
                                input string name);
        int waited;
        writeOperands(mcand, mplier, waited);
        waitForResults(1);
        readAndCheckResult(name);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] rnd;
        logic [31:0] rdata;
        logic [31:0] statusBefore;
        logic        err;
        int          waited;
        int          burstWait [BURST_JOBS];
        reset         = 1'b1;
        apbReq        = '0;
        lcgState      = 32'h7fe25839;
        expTag        = '0;
        mismatches    = 0;
        otherFailures = 0;
        #1;
        reset = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b1;
        @(posedge clk);
        #2;

        apbAccess(1'b0, `ADDR_STATUS, '0, rdata, err, waited);
        expectEqual("reset status", 32'd0, rdata);

        for (int i = 0; i < 12; i++) begin
            rnd = nextRandom();
            checkProduct(rnd[15:0], rnd[31:16], "random");
        end

        checkProduct(16'h8000, 16'h8000, "min times min");
        checkProduct(16'h8000, 16'h0001, "min times one");
        checkProduct(16'h7fff, 16'hffff, "max times minus one");
        rnd = nextRandom();
        checkProduct(16'h0000, rnd[15:0], "zero times value");
        checkProduct(rnd[31:16], 16'h0000, "value times zero");

        // more jobs than units; the first extra write stalls on pready,
        // later ones find a unit freed two cycles apart.
        for (int i = 0; i < BURST_JOBS; i++) begin
            rnd = nextRandom();
            writeOperands(rnd[15:0], rnd[31:16], burstWait[i]);
        end
        for (int i = 0; i < BURST_JOBS; i++) begin
            expectEqual("burst stall", {31'd0, i == `MUL_UNITS}, {31'd0, burstWait[i] > 0});
        end
        waitForResults(BURST_JOBS);
        for (int i = 0; i < BURST_JOBS; i++) begin
            readAndCheckResult("burst order");
        end

        apbAccess(1'b0, `ADDR_RESULT, '0, rdata, err, waited);
        expectEqual("empty result data", 32'd0, rdata);
        expectEqual("empty result error", 32'd1, {31'd0, err});
        apbAccess(1'b0, 12'h010, '0, rdata, err, waited);
        expectEqual("unmapped read error", 32'd1, {31'd0, err});
        apbAccess(1'b0, `ADDR_STATUS, '0, statusBefore, err, waited);
        apbAccess(1'b1, `ADDR_STATUS, 32'hffff_ffff, rdata, err, waited);
        expectEqual("status write error", 32'd0, {31'd0, err});
        apbAccess(1'b0, `ADDR_STATUS, '0, rdata, err, waited);
        expectEqual("status after write", statusBefore, rdata);

        repeat (2) @(posedge clk);
        assertFails = UUT.uRegs.uApbChecks.failCount + UUT.uDispatch.uUnitChecks.failCount;
        $display("errors: mismatches=%0d other=%0d assertions=%0d",
                 mismatches, otherFailures, assertFails);
        if (mismatches == 0 && otherFailures == 0 && assertFails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mulArray_assertions.sv
`default_nettype none

`include "mulArray_params.svh"

module mulArray_assertions (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  mulArray_pkg::apbReq_t      apbReq,
    input  mulArray_pkg::apbRsp_t      apbRsp,
    input  wire logic                  jobValid,
    input  wire logic [`MUL_UNITS-1:0] start,
    input  wire logic [`MUL_UNITS-1:0] busy
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    slverrWithReady: assert property (@(posedge clk) disable iff (!reset)
        apbRsp.pslverr |-> (apbRsp.pready && apbReq.psel && apbReq.penable))
    else begin
        failCount++;
        $error("pslverr raised outside a completing access cycle");
    end

    jobOnlyOnOperands: assert property (@(posedge clk) disable iff (!reset)
        jobValid |-> (apbReq.psel && apbReq.penable && apbReq.pwrite
                      && apbReq.paddr == `ADDR_OPERANDS))
    else begin
        failCount++;
        $error("jobValid high outside an operand write");
    end

    // control outputs stay quiet while reset is held.
    quietInReset: assert property (@(posedge clk)
        !reset |-> (!apbRsp.pready && !apbRsp.pslverr && start == '0 && busy == '0))
    else begin
        failCount++;
        $error("control output active during reset");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // unit occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    startOneHot: assert property (@(posedge clk) disable iff (!reset)
        $onehot0(start))
    else begin
        failCount++;
        $error("more than one unit started in a cycle");
    end

    startToFreeUnit: assert property (@(posedge clk) disable iff (!reset)
        (start & busy) == '0)
    else begin
        failCount++;
        $error("start issued to a busy unit");
    end

endmodule

// register block sees the APB side only.
bind apbMulRegs mulArray_assertions uApbChecks (
    .clk      (clk),
    .reset    (reset),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .jobValid (jobValid),
    .start    ('0),
    .busy     ('0)
);

bind jobDispatcher mulArray_assertions uUnitChecks (
    .clk      (clk),
    .reset    (reset),
    .apbReq   ('0),
    .apbRsp   ('0),
    .jobValid (1'b0),
    .start    (start),
    .busy     (busy)
);

`default_nettype wire

//--- mulArray.sv
`default_nettype none

`include "mulArray_params.svh"

module mulArray (
    input  wire logic              clk,
    input  wire logic              reset,
    input  mulArray_pkg::apbReq_t  apbReq,
    output mulArray_pkg::apbRsp_t  apbRsp
);
    import mulArray_pkg::*;

    mulJob_t               job;
    mulJob_t               unitJob;
    logic                  jobValid;
    logic                  jobReady;
    logic [`MUL_UNITS-1:0] start;
    logic [`MUL_UNITS-1:0] busy;
    logic [`MUL_UNITS-1:0] done;
    logic [`MUL_UNITS-1:0] accept;
    mulResult_t            unitResult [`MUL_UNITS];
    mulResult_t            resHead;
    logic [3:0]            resCount;
    logic                  resPop;

    apbMulRegs uRegs (
        .clk      (clk),
        .reset    (reset),
        .apbReq   (apbReq),
        .jobReady (jobReady),
        .resHead  (resHead),
        .resCount (resCount),
        .apbRsp   (apbRsp),
        .job      (job),
        .jobValid (jobValid),
        .resPop   (resPop)
    );

    jobDispatcher uDispatch (
        .clk      (clk),
        .reset    (reset),
        .job      (job),
        .jobValid (jobValid),
        .busy     (busy),
        .jobReady (jobReady),
        .start    (start),
        .unitJob  (unitJob)
    );

    for (genvar i = 0; i < `MUL_UNITS; i++) begin : gUnit
        seqMultiplier uMul (
            .clk    (clk),
            .reset  (reset),
            .start  (start[i]),
            .job    (unitJob),
            .accept (accept[i]),
            .busy   (busy[i]),
            .done   (done[i]),
            .result (unitResult[i])
        );
    end

    resultCollector uCollect (
        .clk        (clk),
        .reset      (reset),
        .done       (done),
        .unitResult (unitResult),
        .resPop     (resPop),
        .accept     (accept),
        .resHead    (resHead),
        .resCount   (resCount)
    );

endmodule

`default_nettype wire

//--- apbMulRegs.sv
`default_nettype none

`include "mulArray_params.svh"

module apbMulRegs (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  mulArray_pkg::apbReq_t     apbReq,
    input  wire logic                 jobReady,
    input  mulArray_pkg::mulResult_t  resHead,
    input  wire logic [3:0]           resCount,
    output mulArray_pkg::apbRsp_t     apbRsp,
    output mulArray_pkg::mulJob_t     job,
    output logic                      jobValid,
    output logic                      resPop
);

    logic                  access;
    logic                  rdAccess;
    logic                  isOperands;
    logic                  isStatus;
    logic                  isResult;
    logic                  isTag;
    logic                  mapped;
    logic                  resEmpty;
    logic [`TAG_WIDTH-1:0] nextTag;
    logic [31:0]           statusWord;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign access     = apbReq.psel && apbReq.penable;
    assign rdAccess   = access && !apbReq.pwrite;
    assign isOperands = (apbReq.paddr == `ADDR_OPERANDS);
    assign isStatus   = (apbReq.paddr == `ADDR_STATUS);
    assign isResult   = (apbReq.paddr == `ADDR_RESULT);
    assign isTag      = (apbReq.paddr == `ADDR_TAG);
    assign mapped     = isOperands || isStatus || isResult || isTag;
    assign resEmpty   = (resCount == 4'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // job path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign jobValid = access && apbReq.pwrite && isOperands;

    always_comb begin
        job.multiplicand = apbReq.pwdata[15:0];
        job.multiplier   = apbReq.pwdata[31:16];
        job.tag          = nextTag;
    end

    // tag advances once per accepted job, wrapping.
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            nextTag <= '0;
        end else if (jobValid && jobReady) begin
            nextTag <= nextTag + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pending count, full flag, next tag.
    assign statusWord = {16'h0000, nextTag, 3'b000, !jobReady, 4'h0, resCount};

    always_comb begin
        apbRsp.prdata = '0;
        if (rdAccess) begin
            if (isStatus) begin
                apbRsp.prdata = statusWord;
            end else if (isResult && !resEmpty) begin
                apbRsp.prdata = resHead.product;
            end else if (isTag) begin
                apbRsp.prdata = {{(32 - `TAG_WIDTH){1'b0}}, resHead.tag};
            end
        end
    end

    // operand writes wait for a free unit.
    assign apbRsp.pready  = jobValid ? jobReady : access;
    assign apbRsp.pslverr = access && (!mapped || (isResult && !apbReq.pwrite && resEmpty));

    assign resPop = rdAccess && isResult && !resEmpty;

endmodule

`default_nettype wire

//--- resultCollector.sv
`default_nettype none

`include "mulArray_params.svh"

module resultCollector (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [`MUL_UNITS-1:0] done,
    input  mulArray_pkg::mulResult_t   unitResult [`MUL_UNITS],
    input  wire logic                  resPop,
    output logic [`MUL_UNITS-1:0]      accept,
    output mulArray_pkg::mulResult_t   resHead,
    output logic [3:0]                 resCount
);
    import mulArray_pkg::*;

    localparam int PTR_W  = $clog2(`RES_DEPTH);
    localparam int UNIT_W = $clog2(`MUL_UNITS);

    mulResult_t            fifoMem [`RES_DEPTH];
    logic [PTR_W-1:0]      wrPtr;
    logic [PTR_W-1:0]      rdPtr;
    logic [3:0]            count;
    logic                  full;
    logic                  push;
    logic                  pop;
    logic [UNIT_W-1:0]     pushIdx;
    logic [`MUL_UNITS-1:0] lowDone;

    assign full = (count == `RES_DEPTH);

    // lowest pending unit wins when several are done.
    assign lowDone = done & (~done + 1'b1);
    assign accept  = full ? '0 : lowDone;

    always_comb begin
        pushIdx = '0;
        for (int i = `MUL_UNITS - 1; i >= 0; i--) begin
            if (done[i]) begin
                pushIdx = UNIT_W'(i);
            end
        end
    end

    assign push = (|done) && !full;
    assign pop  = resPop && (count != 0);

    always_ff @(posedge clk) begin
        if (push) begin
            fifoMem[wrPtr] <= unitResult[pushIdx];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign resHead  = fifoMem[rdPtr];
    assign resCount = count;

endmodule

`default_nettype wire

//--- jobDispatcher.sv
`default_nettype none

`include "mulArray_params.svh"

module jobDispatcher (
    input  wire logic               clk,
    input  wire logic               reset,
    input  mulArray_pkg::mulJob_t   job,
    input  wire logic               jobValid,
    input  wire logic [`MUL_UNITS-1:0] busy,
    output logic                    jobReady,
    output logic [`MUL_UNITS-1:0]   start,
    output mulArray_pkg::mulJob_t   unitJob
);

    logic [`MUL_UNITS-1:0] startQ;
    logic [`MUL_UNITS-1:0] freeMask;
    logic [`MUL_UNITS-1:0] grant;

    // a unit started last cycle may not show busy yet.
    assign freeMask = ~(busy | startQ);

    // isolate the lowest free unit.
    assign grant = freeMask & (~freeMask + 1'b1);

    assign jobReady = |freeMask;

    // grant is zero whenever no unit is free.
    assign start = jobValid ? grant : '0;

    // all units see the same job word, only the start pulse selects.
    assign unitJob = job;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            startQ <= '0;
        end else begin
            startQ <= start;
        end
    end

endmodule

`default_nettype wire

//--- seqMultiplier.sv
`default_nettype none

`include "mulArray_params.svh"

module seqMultiplier (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 start,
    input  mulArray_pkg::mulJob_t     job,
    input  wire logic                 accept,
    output logic                      busy,
    output logic                      done,
    output mulArray_pkg::mulResult_t  result
);
    import mulArray_pkg::*;

    localparam int STEP_W = $clog2(`MUL_WIDTH);
    localparam int PROD_W = 2 * `MUL_WIDTH;

    mulJob_t             jobReg;
    logic [STEP_W-1:0]   stepCnt;
    logic [PROD_W-1:0]   partialSum;
    logic [PROD_W-1:0]   extMcand;
    logic [PROD_W-1:0]   shifted;
    logic [PROD_W-1:0]   nextSum;
    logic                mulBit;
    logic                lastStep;
    logic                stepping;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign stepping = busy && !done;
    assign lastStep = (stepCnt == STEP_W'(`MUL_WIDTH - 1));

    // multiplicand sign extended to product width.
    assign extMcand = {{`MUL_WIDTH{jobReg.multiplicand[`MUL_WIDTH-1]}}, jobReg.multiplicand};
    assign shifted  = extMcand << stepCnt;
    assign mulBit   = jobReg.multiplier[stepCnt];

    // the top multiplier bit carries negative weight.
    always_comb begin
        nextSum = partialSum;
        if (mulBit) begin
            if (lastStep) begin
                nextSum = partialSum - shifted;
            end else begin
                nextSum = partialSum + shifted;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            jobReg     <= job;
            partialSum <= '0;
        end else if (stepping) begin
            partialSum <= nextSum;
            if (lastStep) begin
                result.product <= nextSum;
                result.tag     <= jobReg.tag;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // load cycle, then one step per cycle, then done until accepted.
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            stepCnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            done    <= 1'b0;
            stepCnt <= '0;
        end else if (stepping) begin
            stepCnt <= stepCnt + 1'b1;
            if (lastStep) begin
                done <= 1'b1;
            end
        end else if (done && accept) begin
            // unit is free again from the next cycle.
            done <= 1'b0;
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- mulArray_pkg.sv
`default_nettype none

`include "mulArray_params.svh"

package mulArray_pkg;

    // one multiply request as it travels to a unit.
    typedef struct packed {
        logic signed [`MUL_WIDTH-1:0] multiplicand;
        logic signed [`MUL_WIDTH-1:0] multiplier;
        logic [`TAG_WIDTH-1:0]        tag;
    } mulJob_t;

    // finished product with the tag of its job.
    typedef struct packed {
        logic signed [2*`MUL_WIDTH-1:0] product;
        logic [`TAG_WIDTH-1:0]          tag;
    } mulResult_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire

//--- mulArray_params.svh
`ifndef MULARRAY_PARAMS_SVH
`define MULARRAY_PARAMS_SVH

// operand width of each multiplier unit.
`define MUL_WIDTH 16

// number of identical units behind the dispatcher.
`define MUL_UNITS 4

// result FIFO entries, a power of two.
`define RES_DEPTH 8

`define TAG_WIDTH 4

// APB register map.
`define ADDR_OPERANDS 12'h000
`define ADDR_STATUS   12'h004
`define ADDR_RESULT   12'h008
`define ADDR_TAG      12'h00C

`endif
